//--- logic/proc_macros.svh
`ifndef PROC_MACROS_SVH
`define PROC_MACROS_SVH

// Datapath and instruction word width
`define WORD_W 16

// Both memories are word addressed
`define IMEM_AW 8
`define IMEM_DEPTH 256
`define DMEM_AW 8
`define DMEM_DEPTH 256

// Eight general registers, R0 is not hardwired
`define REG_AW 3
`define REG_CNT 8

// NOP opcode with every other field zero
`define NOP_WORD 16'h0800

`endif

//--- logic/procPkg.sv
`include "proc_macros.svh"

package procPkg;

   // Major opcodes, the R-type ops share one and are split by func
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opAddi  = 5'b01000,
      opBeqz  = 5'b01100,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opRType = 5'b11011
   } opcodeT;

   typedef struct packed {
      opcodeT             op;
      logic [`REG_AW-1:0] rs;
      logic [`REG_AW-1:0] rt;
      logic [`REG_AW-1:0] rd;
      logic [1:0]         func;
   } rViewT;

   typedef struct packed {
      opcodeT             op;
      logic [`REG_AW-1:0] rs;
      logic [`REG_AW-1:0] rd;
      logic [4:0]         imm5;
   } iViewT;

   // J takes {rs, off8} as its 11-bit offset
   typedef struct packed {
      opcodeT             op;
      logic [`REG_AW-1:0] rs;
      logic [7:0]         off8;
   } bViewT;

   typedef union packed {
      rViewT rView;
      iViewT iView;
      bViewT bView;
   } instrT;

   typedef struct packed {
      logic       regWrite;
      logic       aluSrcImm;
      logic [1:0] aluOp;
      logic       memRead;
      logic       memWrite;
      logic       isBranch;
      logic       isJump;
      logic       isHalt;
      logic       illegal;
   } ctrlT;

endpackage

//--- logic/instrMem.sv
`timescale 1ns/1ps
`include "proc_macros.svh"

module instrMem (
   input  logic                clk,
   input  logic                rstN,
   input  logic                loadEn,
   input  logic [`IMEM_AW-1:0] loadAddr,
   input  logic [`WORD_W-1:0]  loadData,
   input  logic [`IMEM_AW-1:0] rdAddr,
   output logic [`WORD_W-1:0]  rdData
);

   logic [`WORD_W-1:0] mem [`IMEM_DEPTH];

   // Program load is only accepted while the core sits in reset
   always_ff @(posedge clk) begin
      if (!rstN && loadEn) begin
         mem[loadAddr] <= loadData;
      end
   end

   // Fetch reads straight off the PC
   assign rdData = mem[rdAddr];

endmodule

//--- logic/fetchStage.sv
`timescale 1ns/1ps
`include "proc_macros.svh"

module fetchStage (
   input  logic                clk,
   input  logic                rstN,
   input  logic                stall,
   input  logic                redirect,
   input  logic [`IMEM_AW-1:0] redirectPc,
   input  logic                halted,
   input  logic [`WORD_W-1:0]  imemData,
   output logic [`IMEM_AW-1:0] imemAddr,
   output procPkg::instrT      fdInstr,
   output logic [`IMEM_AW-1:0] fdPc
);

   logic [`IMEM_AW-1:0] pc;

   // Redirect wins over a stall, a halted core stops counting
   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= '0;
      end else if (redirect) begin
         pc <= redirectPc;
      end else if (!stall && !halted) begin
         pc <= pc + 1'b1;
      end
   end

   assign imemAddr = pc;

   // Fetch/decode register, squashed on a taken branch or jump
   always_ff @(posedge clk) begin
      if (!rstN) begin
         fdInstr <= `NOP_WORD;
      end else if (redirect || halted) begin
         fdInstr <= `NOP_WORD;
      end else if (!stall) begin
         fdInstr <= imemData;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         fdPc <= pc;
      end
   end

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/1ps
`include "proc_macros.svh"

module decodeStage (
   input  logic                clk,
   input  logic                rstN,
   input  logic                stall,
   input  logic                flush,
   input  procPkg::instrT      fdInstr,
   input  logic [`IMEM_AW-1:0] fdPc,
   input  logic                wbEn,
   input  logic [`REG_AW-1:0]  wbAddr,
   input  logic [`WORD_W-1:0]  wbData,
   output procPkg::ctrlT       dxCtrl,
   output logic [`REG_AW-1:0]  dxRs,
   output logic [`REG_AW-1:0]  dxRt,
   output logic [`REG_AW-1:0]  dxRd,
   output logic [`WORD_W-1:0]  dxVal1,
   output logic [`WORD_W-1:0]  dxVal2,
   output logic [`WORD_W-1:0]  dxImm,
   output logic [`IMEM_AW-1:0] dxPc,
   output logic [`REG_AW-1:0]  decRs,
   output logic [`REG_AW-1:0]  decRt
);

   import procPkg::*;

   ctrlT               ctrl;
   logic [`REG_AW-1:0] decRd;
   logic [`WORD_W-1:0] imm;
   logic [`WORD_W-1:0] rf [`REG_CNT];
   logic [`WORD_W-1:0] rdVal1;
   logic [`WORD_W-1:0] rdVal2;

   always_comb begin
      ctrl  = '0;
      decRs = fdInstr.rView.rs;
      // For a store the rt field names the data register
      decRt = fdInstr.rView.rt;
      decRd = fdInstr.iView.rd;
      imm   = {{(`WORD_W-5){fdInstr.iView.imm5[4]}}, fdInstr.iView.imm5};
      case (fdInstr.rView.op)
         opHalt: ctrl.isHalt = 1'b1;
         opNop:  ctrl = '0;
         opRType: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = fdInstr.rView.func;
            decRd         = fdInstr.rView.rd;
         end
         opAddi: begin
            ctrl.regWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
         end
         opLd: begin
            ctrl.regWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            ctrl.memRead   = 1'b1;
         end
         opSt: begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.memWrite  = 1'b1;
         end
         opBeqz: begin
            ctrl.isBranch = 1'b1;
            imm = {{(`WORD_W-8){fdInstr.bView.off8[7]}}, fdInstr.bView.off8};
         end
         opJ: begin
            ctrl.isJump = 1'b1;
            imm = {{(`WORD_W-11){fdInstr.bView.rs[2]}}, fdInstr.bView.rs,
                   fdInstr.bView.off8};
         end
         default: ctrl.illegal = 1'b1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `REG_CNT; i++) begin
            rf[i] <= '0;
         end
      end else if (wbEn) begin
         rf[wbAddr] <= wbData;
      end
   end

   // Writeback in the same cycle is seen by the read
   assign rdVal1 = (wbEn && wbAddr == decRs) ? wbData : rf[decRs];
   assign rdVal2 = (wbEn && wbAddr == decRt) ? wbData : rf[decRt];

   // Stall or flush turns the slot into a bubble
   always_ff @(posedge clk) begin
      if (!rstN) begin
         dxCtrl <= '0;
      end else if (stall || flush) begin
         dxCtrl <= '0;
      end else begin
         dxCtrl <= ctrl;
      end
   end

   always_ff @(posedge clk) begin
      dxRs   <= decRs;
      dxRt   <= decRt;
      dxRd   <= decRd;
      dxVal1 <= rdVal1;
      dxVal2 <= rdVal2;
      dxImm  <= imm;
      dxPc   <= fdPc;
   end

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/1ps
`include "proc_macros.svh"

module hazardUnit (
   input  logic [`REG_AW-1:0] decRs,
   input  logic [`REG_AW-1:0] decRt,
   input  logic [`REG_AW-1:0] dxRs,
   input  logic [`REG_AW-1:0] dxRt,
   input  logic [`REG_AW-1:0] dxRd,
   input  logic               dxMemRead,
   input  logic [`REG_AW-1:0] xmRd,
   input  logic               xmRegWrite,
   input  logic [`REG_AW-1:0] mwRd,
   input  logic               mwRegWrite,
   output logic               stall,
   output logic [1:0]         fwdA,
   output logic [1:0]         fwdB
);

   // 01 takes the memory stage result, 10 writeback, 00 the register file
   function automatic logic [1:0] fwdSel(input logic [`REG_AW-1:0] src,
                                         input logic [`REG_AW-1:0] mRd,
                                         input logic               mWr,
                                         input logic [`REG_AW-1:0] wRd,
                                         input logic               wWr);
      if (mWr && mRd == src) begin
         return 2'b01;
      end else if (wWr && wRd == src) begin
         return 2'b10;
      end
      return 2'b00;
   endfunction

   always_comb begin
      fwdA = fwdSel(dxRs, xmRd, xmRegWrite, mwRd, mwRegWrite);
      fwdB = fwdSel(dxRt, xmRd, xmRegWrite, mwRd, mwRegWrite);
   end

   // Load data is not ready until writeback, hold the consumer one cycle
   assign stall = dxMemRead && (dxRd == decRs || dxRd == decRt);

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ps
`include "proc_macros.svh"

module executeStage (
   input  logic                clk,
   input  logic                rstN,
   input  procPkg::ctrlT       dxCtrl,
   input  logic [`WORD_W-1:0]  dxVal1,
   input  logic [`WORD_W-1:0]  dxVal2,
   input  logic [`REG_AW-1:0]  dxRd,
   input  logic [`WORD_W-1:0]  dxImm,
   input  logic [`IMEM_AW-1:0] dxPc,
   input  logic [1:0]          fwdA,
   input  logic [1:0]          fwdB,
   input  logic [`WORD_W-1:0]  xmFwdVal,
   input  logic [`WORD_W-1:0]  mwFwdVal,
   output logic                redirect,
   output logic [`IMEM_AW-1:0] redirectPc,
   output procPkg::ctrlT       xmCtrl,
   output logic [`WORD_W-1:0]  xmAlu,
   output logic [`WORD_W-1:0]  xmStoreData,
   output logic [`REG_AW-1:0]  xmRd
);

   logic [`WORD_W-1:0] opA;
   logic [`WORD_W-1:0] opB;
   logic [`WORD_W-1:0] aluB;
   logic [`WORD_W-1:0] aluOut;
   logic [`WORD_W-1:0] target;

   function automatic logic [`WORD_W-1:0] pickOperand(input logic [1:0]         sel,
                                                      input logic [`WORD_W-1:0] regVal,
                                                      input logic [`WORD_W-1:0] mVal,
                                                      input logic [`WORD_W-1:0] wVal);
      case (sel)
         2'b01:   return mVal;
         2'b10:   return wVal;
         default: return regVal;
      endcase
   endfunction

   always_comb begin
      opA = pickOperand(fwdA, dxVal1, xmFwdVal, mwFwdVal);
      opB = pickOperand(fwdB, dxVal2, xmFwdVal, mwFwdVal);
   end

   assign aluB = dxCtrl.aluSrcImm ? dxImm : opB;

   // aluOp follows the R-type func field, ADDI and memory ops use add
   always_comb begin
      case (dxCtrl.aluOp)
         2'b00:   aluOut = opA + aluB;
         2'b01:   aluOut = opA - aluB;
         2'b10:   aluOut = opA & aluB;
         default: aluOut = opA ^ aluB;
      endcase
   end

   // Branch and jump share one target, PC plus one plus offset
   assign target     = `WORD_W'(dxPc) + `WORD_W'(1) + dxImm;
   assign redirectPc = target[`IMEM_AW-1:0];
   assign redirect   = (dxCtrl.isBranch && opA == '0) || dxCtrl.isJump;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         xmCtrl <= '0;
      end else begin
         xmCtrl <= dxCtrl;
      end
   end

   always_ff @(posedge clk) begin
      xmAlu       <= aluOut;
      xmStoreData <= opB;
      xmRd        <= dxRd;
   end

endmodule

//--- logic/memoryStage.sv
`timescale 1ns/1ps
`include "proc_macros.svh"

module memoryStage (
   input  logic               clk,
   input  logic               rstN,
   input  procPkg::ctrlT      xmCtrl,
   input  logic [`WORD_W-1:0] xmAlu,
   input  logic [`WORD_W-1:0] xmStoreData,
   input  logic [`REG_AW-1:0] xmRd,
   output logic               wbEn,
   output logic [`REG_AW-1:0] wbAddr,
   output logic [`WORD_W-1:0] wbData,
   output logic               halted,
   output logic               err
);

   logic [`WORD_W-1:0]  dmem [`DMEM_DEPTH];
   logic [`DMEM_AW-1:0] dAddr;
   logic [`WORD_W-1:0]  loadData;
   logic                mwRegWrite;
   logic                mwMemRead;
   logic [`WORD_W-1:0]  mwAlu;
   logic [`WORD_W-1:0]  mwLoad;
   logic [`REG_AW-1:0]  mwRd;

   assign dAddr    = xmAlu[`DMEM_AW-1:0];
   assign loadData = dmem[dAddr];

   // Stores behind a halt never land
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (xmCtrl.memWrite && !halted) begin
         dmem[dAddr] <= xmStoreData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         mwRegWrite <= 1'b0;
         mwMemRead  <= 1'b0;
      end else begin
         mwRegWrite <= xmCtrl.regWrite && !halted;
         mwMemRead  <= xmCtrl.memRead;
      end
   end

   always_ff @(posedge clk) begin
      mwAlu  <= xmAlu;
      mwLoad <= loadData;
      mwRd   <= xmRd;
   end

   // Sticky until reset, rise as the halt or bad opcode enters writeback
   always_ff @(posedge clk) begin
      if (!rstN) begin
         halted <= 1'b0;
         err    <= 1'b0;
      end else begin
         halted <= halted || xmCtrl.isHalt || xmCtrl.illegal;
         err    <= err || (xmCtrl.illegal && !halted);
      end
   end

   assign wbEn   = mwRegWrite;
   assign wbAddr = mwRd;
   assign wbData = mwMemRead ? mwLoad : mwAlu;

endmodule

//--- logic/pipeProc.sv
`timescale 1ns/1ps
`include "proc_macros.svh"

module pipeProc (
   input  logic                clk,
   input  logic                rstN,
   input  logic                loadEn,
   input  logic [`IMEM_AW-1:0] loadAddr,
   input  logic [`WORD_W-1:0]  loadData,
   output logic                halted,
   output logic                err,
   output logic                wbEn,
   output logic [`REG_AW-1:0]  wbAddr,
   output logic [`WORD_W-1:0]  wbData
);

   import procPkg::*;

   // Fetch side
   logic [`IMEM_AW-1:0] imemAddr;
   logic [`WORD_W-1:0]  imemData;
   instrT               fdInstr;
   logic [`IMEM_AW-1:0] fdPc;
   logic                stall;
   logic                redirect;
   logic [`IMEM_AW-1:0] redirectPc;

   // Decode to execute
   ctrlT                dxCtrl;
   logic [`REG_AW-1:0]  dxRs;
   logic [`REG_AW-1:0]  dxRt;
   logic [`REG_AW-1:0]  dxRd;
   logic [`WORD_W-1:0]  dxVal1;
   logic [`WORD_W-1:0]  dxVal2;
   logic [`WORD_W-1:0]  dxImm;
   logic [`IMEM_AW-1:0] dxPc;
   logic [`REG_AW-1:0]  decRs;
   logic [`REG_AW-1:0]  decRt;
   logic [1:0]          fwdA;
   logic [1:0]          fwdB;

   // Execute to memory
   ctrlT                xmCtrl;
   logic [`WORD_W-1:0]  xmAlu;
   logic [`WORD_W-1:0]  xmStoreData;
   logic [`REG_AW-1:0]  xmRd;

   instrMem instrMem0 (.clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr),
                       .loadData(loadData), .rdAddr(imemAddr), .rdData(imemData));

   fetchStage fetch0 (.clk(clk), .rstN(rstN), .stall(stall), .redirect(redirect),
                      .redirectPc(redirectPc), .halted(halted), .imemData(imemData),
                      .imemAddr(imemAddr), .fdInstr(fdInstr), .fdPc(fdPc));

   decodeStage decode0 (.clk(clk), .rstN(rstN), .stall(stall), .flush(redirect),
                        .fdInstr(fdInstr), .fdPc(fdPc), .wbEn(wbEn), .wbAddr(wbAddr),
                        .wbData(wbData), .dxCtrl(dxCtrl), .dxRs(dxRs), .dxRt(dxRt),
                        .dxRd(dxRd), .dxVal1(dxVal1), .dxVal2(dxVal2), .dxImm(dxImm),
                        .dxPc(dxPc), .decRs(decRs), .decRt(decRt));

   hazardUnit hazard0 (.decRs(decRs), .decRt(decRt), .dxRs(dxRs), .dxRt(dxRt), .dxRd(dxRd),
                       .dxMemRead(dxCtrl.memRead), .xmRd(xmRd),
                       .xmRegWrite(xmCtrl.regWrite), .mwRd(wbAddr), .mwRegWrite(wbEn),
                       .stall(stall), .fwdA(fwdA), .fwdB(fwdB));

   executeStage execute0 (.clk(clk), .rstN(rstN), .dxCtrl(dxCtrl), .dxVal1(dxVal1),
                          .dxVal2(dxVal2), .dxRd(dxRd), .dxImm(dxImm), .dxPc(dxPc),
                          .fwdA(fwdA), .fwdB(fwdB), .xmFwdVal(xmAlu), .mwFwdVal(wbData),
                          .redirect(redirect), .redirectPc(redirectPc), .xmCtrl(xmCtrl),
                          .xmAlu(xmAlu), .xmStoreData(xmStoreData), .xmRd(xmRd));

   memoryStage memory0 (.clk(clk), .rstN(rstN), .xmCtrl(xmCtrl), .xmAlu(xmAlu),
                        .xmStoreData(xmStoreData), .xmRd(xmRd), .wbEn(wbEn),
                        .wbAddr(wbAddr), .wbData(wbData), .halted(halted), .err(err));

endmodule

//--- sim/pipeProcTb.sv
`timescale 1ns/1ps
`include "proc_macros.svh"

module pipeProcTb;

   import procPkg::*;

   localparam int clkPeriod  = 10;
   localparam int numProgs   = 8;
   localparam int maxLen     = 24;
   localparam int padWords   = 4;
   // Reset and load, 20 cycles per instruction, then the settle window
   localparam int progBudget = maxLen + padWords + 8 + maxLen * 20 + 12;
   localparam int watchdogNs = numProgs * progBudget * clkPeriod;

   logic                clk;
   logic                rstN;
   logic                loadEn;
   logic [`IMEM_AW-1:0] loadAddr;
   logic [`WORD_W-1:0]  loadData;
   logic                halted;
   logic                err;
   logic                wbEn;
   logic [`REG_AW-1:0]  wbAddr;
   logic [`WORD_W-1:0]  wbData;

   integer seed      = 45127;
   int     valueErrs = 0;
   int     otherErrs = 0;

   logic [`WORD_W-1:0]         prog [maxLen + padWords];
   int                         progLen;
   logic [`WORD_W-1:0]         refRegs [`REG_CNT];
   logic [`WORD_W-1:0]         refMem [`DMEM_DEPTH];
   logic [`IMEM_AW-1:0]        refPc;
   logic [`REG_AW+`WORD_W-1:0] expQ [$];
   logic [`REG_AW+`WORD_W-1:0] expEntry;
   logic                       expErr;

   pipeProc u_pipeProc (.clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr),
                        .loadData(loadData), .halted(halted), .err(err), .wbEn(wbEn),
                        .wbAddr(wbAddr), .wbData(wbData));

   initial clk = 1'b0;
   always #(clkPeriod / 2) clk = ~clk;

   function automatic int randBelow(input int n);
      int r;
      r = $random(seed) & 32'h7fff_ffff;
      return r % n;
   endfunction

   function automatic logic [15:0] encR(input logic [1:0] func, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [2:0] rt);
      return {opRType, rs, rt, rd, func};
   endfunction

   function automatic logic [15:0] encI(input opcodeT op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   task automatic compareValue(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp) begin
         valueErrs++;
         $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   // Kind 0 ALU only, 1 memory pairs, 2 full mix with branches, 3 mix plus a bad opcode
   task automatic buildProgram(input int kind);
      int         n;
      int         i;
      int         cat;
      int         maxOff;
      int         regSpan;
      logic [2:0] ra;
      logic [2:0] rb;
      logic [2:0] rc;
      n       = 12 + randBelow(maxLen - 12);
      regSpan = (kind == 0) ? 4 : 8;
      i       = 0;
      while (i < n - 1) begin
         ra     = 3'(randBelow(regSpan));
         rb     = 3'(randBelow(regSpan));
         rc     = 3'(randBelow(regSpan));
         maxOff = n - 2 - i;
         case (kind)
            0:       cat = randBelow(2);
            1:       cat = randBelow(4);
            default: cat = randBelow(7);
         endcase
         case (cat)
            0:       prog[i] = encR(2'(randBelow(4)), ra, rb, rc);
            1:       prog[i] = encI(opAddi, ra, rb, 5'(randBelow(32)));
            2:       prog[i] = encI(opLd, ra, rb, 5'(randBelow(32)));
            3:       prog[i] = encI(opSt, ra, rb, 5'(randBelow(32)));
            4:       prog[i] = {opBeqz, rb, 8'(randBelow(maxOff + 1))};
            5:       prog[i] = {opJ, 11'(randBelow(maxOff + 1))};
            default: prog[i] = `NOP_WORD;
         endcase
         // Store then load of the same address, or a load then an immediate use
         if (kind == 1 && cat >= 2 && i < n - 2) begin
            if (cat == 3) begin
               prog[i + 1] = encI(opLd, rc, rb, prog[i][4:0]);
            end else begin
               prog[i + 1] = encR(2'(randBelow(4)), rc, ra, rb);
            end
            i++;
         end
         i++;
      end
      if (kind == 3) begin
         prog[1 + randBelow(n - 2)] = {5'b11111, 11'(randBelow(2048))};
      end
      prog[n - 1] = {opHalt, 11'h000};
      // Fetch runs ahead into these register writes and none of them may retire
      for (int k = n; k < n + padWords; k++) begin
         prog[k] = encI(opAddi, 3'(randBelow(8)), 3'(randBelow(8)), 5'(randBelow(32)));
      end
      progLen = n;
   endtask

   // Runs one instruction on the ISA model and returns 0 to go on, 1 on HALT or 2 on a bad opcode
   function automatic int refStep(input logic [15:0] instr, output logic wr,
                                  output logic [2:0] wAddr, output logic [15:0] wData);
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] sImm5;
      logic [7:0]  addr;
      a     = refRegs[instr[10:8]];
      b     = refRegs[instr[7:5]];
      sImm5 = {{11{instr[4]}}, instr[4:0]};
      addr  = 8'(a + sImm5);
      wr    = 1'b0;
      wAddr = instr[7:5];
      wData = '0;
      refPc = refPc + 8'd1;
      case (instr[15:11])
         opHalt: return 1;
         opNop: begin
         end
         opRType: begin
            wr    = 1'b1;
            wAddr = instr[4:2];
            case (instr[1:0])
               2'd0:    wData = a + b;
               2'd1:    wData = a - b;
               2'd2:    wData = a & b;
               default: wData = a ^ b;
            endcase
         end
         opAddi: begin
            wr    = 1'b1;
            wData = a + sImm5;
         end
         opLd: begin
            wr    = 1'b1;
            wData = refMem[addr];
         end
         opSt: refMem[addr] = b;
         opBeqz: begin
            if (a == 16'h0000) begin
               refPc = refPc + instr[7:0];
            end
         end
         opJ: refPc = refPc + instr[7:0];
         default: return 2;
      endcase
      if (wr) begin
         refRegs[wAddr] = wData;
      end
      return 0;
   endfunction

   task automatic predictTrace();
      logic        wr;
      logic [2:0]  wAddr;
      logic [15:0] wData;
      int          status;
      int          steps;
      foreach (refRegs[r]) refRegs[r] = '0;
      foreach (refMem[m]) refMem[m] = '0;
      refPc  = '0;
      status = 0;
      steps  = 0;
      expQ.delete();
      while (status == 0 && steps < 256) begin
         status = refStep(prog[refPc], wr, wAddr, wData);
         if (wr) begin
            expQ.push_back({wAddr, wData});
         end
         steps++;
      end
      expErr = (status == 2);
   endtask

   // Program words go in through the load port while the core is held in reset
   task automatic loadProgram();
      int words;
      int cycles;
      words  = progLen + padWords;
      cycles = (words > 8) ? words : 8;
      @(posedge clk);
      #1;
      rstN = 1'b0;
      for (int k = 0; k < cycles; k++) begin
         loadEn   = (k < words);
         loadAddr = `IMEM_AW'(k);
         loadData = (k < words) ? prog[k] : '0;
         @(posedge clk);
         #1;
      end
      loadEn = 1'b0;
      rstN   = 1'b1;
   endtask

   task automatic runProgram(input int p);
      buildProgram(p % 4);
      predictTrace();
      loadProgram();
      @(negedge clk);
      compareValue("halted", 32'(halted), 32'd0);
      compareValue("err", 32'(err), 32'd0);
      while (!halted) begin
         @(negedge clk);
      end
      // Give any write behind the halt time to appear
      repeat (10) @(negedge clk);
      if (expQ.size() != 0) begin
         otherErrs++;
         $display("Program %0d stopped with %0d expected register writes missing",
                  p, expQ.size());
      end
      compareValue("halted", 32'(halted), 32'd1);
      compareValue("err", 32'(err), 32'(expErr));
   endtask

   // Each retirement is checked against the next model write
   always @(negedge clk) begin
      if (rstN && wbEn) begin
         if (expQ.size() == 0) begin
            otherErrs++;
            $display("Unexpected register write to r%0d of 0x%h at %0t", wbAddr, wbData,
                     $time);
         end else begin
            expEntry = expQ.pop_front();
            compareValue("wbAddr", 32'(wbAddr), 32'(expEntry[18:16]));
            compareValue("wbData", 32'(wbData), 32'(expEntry[15:0]));
         end
      end
   end

   initial begin
      rstN     = 1'b0;
      loadEn   = 1'b0;
      loadAddr = '0;
      loadData = '0;
      for (int p = 0; p < numProgs; p++) begin
         runProgram(p);
      end
      $display("Errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
      if (valueErrs == 0 && otherErrs == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      #(watchdogNs);
      $display("Timeout: the core did not halt within %0d ns", watchdogNs);
      $display("Errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
      $display("Test failed");
      $finish;
   end

endmodule

//--- pipeProc.f
+incdir+logic
logic/procPkg.sv
logic/instrMem.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/hazardUnit.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/pipeProc.sv
sim/pipeProcTb.sv

//--- Makefile
# Verilator build and run for the pipelined processor testbench

VERILATOR ?= verilator
TOP       ?= pipeProcTb
FILELIST  ?= pipeProc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
